// File: files.f
+incdir+src
src/board_pkg.sv
src/audio_pkg.sv
src/i2s_mic_receiver.sv
src/level_meter.sv
src/seg_latch.sv
src/board_top.sv
verif/i2s_mic_model.sv
verif/tb_board_top.sv

// File: run.sh
#!/bin/sh
# Builds the level display testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_board_top \
    -f files.f \
    -Mdir obj_dir

./obj_dir/Vtb_board_top > sim.log 2>&1 || true
cat sim.log

if grep -qx "=== PASS ===" sim.log
then
    exit 0
fi
exit 1

// File: src/audio_pkg.sv
// Audio sample types and I2S receiver states for the INMP441 path
`default_nettype none

package audio_pkg;

    // Two's complement microphone word, MSB first on the wire
    typedef logic signed [23:0] sample_t;

    typedef logic [23:0] magnitude_t;   // Absolute value, saturated

    // Receiver walk through the left slot of a frame
    typedef enum logic [1:0]
    {
        IDLE_WAIT,  // Waiting for ws to fall
        SKIP_BIT,   // One sck of delay before the MSB
        SHIFT,      // 24 data bits
        HOLD        // Rest of the frame
    } i2s_state_e;

    // Sample with its one-cycle strobe
    typedef struct packed
    {
        sample_t value;
        logic    valid;
    } sample_s;

endpackage

`default_nettype wire

// File: src/board_defs.svh
// Board constants for the microphone level display: clock, I2S, scan and display sizes

`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// ---------------------------------------------------------------------------
// Clocking

`define BOARD_CLK_MHZ   50      // System clock in MHz

// Half period of the I2S bit clock, in clk cycles
`define I2S_SCK_DIV     4

// clk cycles per displayed digit, kept short for simulation
`define SCAN_DIV        16

// ---------------------------------------------------------------------------
// Display resources

`define W_DIGIT         6       // HEX0 to HEX5
`define W_LED_BAR       4       // Lower LEDR used as the level bar

`endif

// File: src/board_pkg.sv
// Display types shared by the level meter, segment latch and board wrapper
`default_nettype none

`include "board_defs.svh"

package board_pkg;

    // ---------------------------------------------------------------------------
    // Segment and digit encodings

    // Segments a to g then the decimal point h, a in the MSB, active high
    typedef logic [7:0] seg_t;

    // One-hot digit select, bit 0 is the rightmost digit
    typedef logic [`W_DIGIT - 1:0] digit_t;

    // Board HEX pins, active low, segment a at bit 0
    typedef logic [6:0] hex_seg_t;

    typedef logic [`W_LED_BAR - 1:0] bar_t;    // Thermometer level bar

    // ---------------------------------------------------------------------------
    // Scanned display bus

    typedef struct packed
    {
        seg_t   abcdefgh;   // Pattern of the selected digit
        digit_t digit;      // Which digit the pattern belongs to
    } scan_s;

endpackage

`default_nettype wire

// File: src/board_top.sv
// Board wrapper for the microphone level display: switches, keys, LEDR, HEX and JP1 pins
`default_nettype none

`include "board_defs.svh"

module board_top
(
    input  wire                 clk,
    input  wire [3:0]           key,        // Active low
    input  wire [9:0]           sw,
    output logic [9:0]          ledr,
    output board_pkg::hex_seg_t hex0,
    output board_pkg::hex_seg_t hex1,
    output board_pkg::hex_seg_t hex2,
    output board_pkg::hex_seg_t hex3,
    output board_pkg::hex_seg_t hex4,
    output board_pkg::hex_seg_t hex5,
    inout  wire [35:0]          gpio_0
);

    localparam int sck_khz = `BOARD_CLK_MHZ * 1000 / (2 * `I2S_SCK_DIV);

    logic                   rst;
    logic                   mode;
    logic                   clear;
    audio_pkg::sample_s     sample;
    board_pkg::scan_s       scan;
    board_pkg::bar_t        bar;
    board_pkg::digit_t      dp;

    // Receiver edge detection needs sck at a quarter of clk or slower
    if (sck_khz * 4 > `BOARD_CLK_MHZ * 1000)
    begin : g_sck_rate_check
        $error("sck too fast for the receiver");
    end

    if (`W_LED_BAR + `W_DIGIT != $bits(ledr))
    begin : g_ledr_width_check
        $error("LEDR does not hold the bar and the points");
    end

    assign rst   = sw[9];
    assign mode  = sw[0];
    assign clear = ~key[0];

    // ---------------------------------------------------------------------------
    // Blocks

    i2s_mic_receiver u_receiver
    (
        .clk    (clk),
        .rst    (rst),
        .sd     (gpio_0[0]),    // JP1 pin 1
        .sck    (gpio_0[1]),    // JP1 pin 2
        .ws     (gpio_0[3]),    // JP1 pin 4
        .lr     (gpio_0[5]),    // JP1 pin 6
        .sample (sample)
    );

    assign gpio_0[2]    = 1'b1;     // Microphone VCC
    assign gpio_0[4]    = 1'b0;     // Microphone GND
    assign gpio_0[35:6] = 'z;

    level_meter u_meter
    (
        .clk    (clk),
        .rst    (rst),
        .sample (sample),
        .mode   (mode),
        .clear  (clear),
        .scan   (scan),
        .bar    (bar)
    );

    seg_latch u_latch
    (
        .clk    (clk),
        .rst    (rst),
        .scan   (scan),
        .hex0   (hex0),
        .hex1   (hex1),
        .hex2   (hex2),
        .hex3   (hex3),
        .hex4   (hex4),
        .hex5   (hex5),
        .dp     (dp)
    );

    assign ledr = {dp, bar};    // Upper six LEDs act as decimal points

endmodule

`default_nettype wire

// File: src/i2s_mic_receiver.sv
// I2S master receiver for an INMP441 microphone: makes sck and ws, captures the left slot
`default_nettype none

`include "board_defs.svh"

module i2s_mic_receiver
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 sd,
    output logic                sck,
    output logic                ws,
    output logic                lr,
    output audio_pkg::sample_s  sample
);

    localparam int w_div = $clog2(`I2S_SCK_DIV + 1);

    logic [w_div - 1:0]     div_cnt;
    logic                   sck_tick;
    logic                   sck_rise;
    logic                   sck_fall;
    logic [5:0]             slot_cnt;       // sck periods within the 64-period frame
    logic [5:0]             next_slot;
    logic [1:0]             sd_sync;
    audio_pkg::i2s_state_e  state;
    logic [4:0]             bit_cnt;
    audio_pkg::sample_t     shift_reg;
    logic                   valid_q;

    assign lr = 1'b0;   // Microphone answers in the left slot

    // ---------------------------------------------------------------------------
    // Bit clock and word select

    assign sck_tick  = (div_cnt == w_div'(`I2S_SCK_DIV - 1));
    assign sck_rise  = sck_tick & ~sck;
    assign sck_fall  = sck_tick &  sck;
    assign next_slot = slot_cnt + 6'd1;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt  <= '0;
            sck      <= 1'b0;
            slot_cnt <= '0;
            ws       <= 1'b0;
        end
        else if (sck_tick)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
            if (sck)
            begin
                slot_cnt <= next_slot;
                ws       <= next_slot[5];   // Low for the first 32 periods
            end
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // Two flops on the pad before sampling
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            sd_sync <= '0;
        else
            sd_sync <= {sd_sync[0], sd};
    end

    // ---------------------------------------------------------------------------
    // Slot capture

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= audio_pkg::IDLE_WAIT;
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            case (state)
                audio_pkg::IDLE_WAIT:
                    if (sck_fall && next_slot == '0)    // ws falls here
                        state <= audio_pkg::SKIP_BIT;
                audio_pkg::SKIP_BIT:
                    if (sck_rise)
                    begin
                        state   <= audio_pkg::SHIFT;
                        bit_cnt <= '0;
                    end
                audio_pkg::SHIFT:
                    if (sck_rise)
                    begin
                        bit_cnt <= bit_cnt + 5'd1;
                        if (bit_cnt == 5'd23)
                        begin
                            state   <= audio_pkg::HOLD;
                            valid_q <= 1'b1;
                        end
                    end
                audio_pkg::HOLD:
                    if (ws)                 // Right slot, rearm for the next frame
                        state <= audio_pkg::IDLE_WAIT;
                default:
                    state <= audio_pkg::IDLE_WAIT;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == audio_pkg::SHIFT && sck_rise)
            shift_reg <= {shift_reg[22:0], sd_sync[1]};
    end

    // Full word sits in the shifter while valid is high
    assign sample.value = shift_reg;
    assign sample.valid = valid_q;

    a_bit_cnt_max: assert property (@(posedge clk) disable iff (rst) bit_cnt <= 5'd24);
    a_valid_pulse: assert property (@(posedge clk) disable iff (rst) valid_q |=> !valid_q);

endmodule

`default_nettype wire

// File: src/level_meter.sv
// Level meter: peak hold, display selection, hex digit scan and LED level bar
`default_nettype none

`include "board_defs.svh"

module level_meter
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire audio_pkg::sample_s     sample,
    input  wire                         mode,       // 0 raw sample, 1 peak
    input  wire                         clear,
    output board_pkg::scan_s            scan,
    output board_pkg::bar_t             bar
);

    localparam int w_scan   = $clog2(`SCAN_DIV + 1);
    localparam int w_idx    = $clog2(`W_DIGIT);
    localparam int bar_base = 19;       // Lowest bar LED lights at 2^19

    // ---------------------------------------------------------------------------
    // Helpers

    // Absolute value, the most negative code clips to full scale
    function automatic audio_pkg::magnitude_t abs_sat(input audio_pkg::sample_t value);
        audio_pkg::magnitude_t mag;
        if (!value[$left(value)])
            mag = value;
        else if (value[$left(value) - 1:0] == '0)
            mag = {1'b0, {($bits(value) - 1){1'b1}}};
        else
            mag = -value;
        return mag;
    endfunction

    function automatic board_pkg::seg_t hex_to_seg(input logic [3:0] nibble);
        board_pkg::seg_t seg;
        case (nibble)
            4'h0: seg = 8'b1111_1100;
            4'h1: seg = 8'b0110_0000;
            4'h2: seg = 8'b1101_1010;
            4'h3: seg = 8'b1111_0010;
            4'h4: seg = 8'b0110_0110;
            4'h5: seg = 8'b1011_0110;
            4'h6: seg = 8'b1011_1110;
            4'h7: seg = 8'b1110_0000;
            4'h8: seg = 8'b1111_1110;
            4'h9: seg = 8'b1111_0110;
            4'ha: seg = 8'b1110_1110;
            4'hb: seg = 8'b0011_1110;
            4'hc: seg = 8'b1001_1100;
            4'hd: seg = 8'b0111_1010;
            4'he: seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;    // F
        endcase
        return seg;
    endfunction

    audio_pkg::sample_t     last_sample;
    audio_pkg::magnitude_t  peak;
    audio_pkg::magnitude_t  new_mag;
    audio_pkg::magnitude_t  disp_value;
    audio_pkg::magnitude_t  disp_mag;
    logic                   sign_point;
    logic [w_scan - 1:0]    scan_cnt;
    logic [w_idx - 1:0]     digit_idx;
    logic [3:0]             nibble;

    // ---------------------------------------------------------------------------
    // Sample and peak registers

    assign new_mag = abs_sat(sample.value);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            last_sample <= '0;
            peak        <= '0;
        end
        else if (sample.valid)
        begin
            last_sample <= sample.value;
            if (clear || new_mag > peak)    // Clear keeps only the new sample
                peak <= new_mag;
        end
        else if (clear)
            peak <= '0;
    end

    assign disp_value = mode ? peak : audio_pkg::magnitude_t'(last_sample);
    assign disp_mag   = mode ? peak : abs_sat(last_sample);
    assign sign_point = !mode && last_sample[$left(last_sample)];

    // ---------------------------------------------------------------------------
    // Digit scan

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end
        else if (scan_cnt == w_scan'(`SCAN_DIV - 1))
        begin
            scan_cnt  <= '0;
            digit_idx <= (digit_idx == w_idx'(`W_DIGIT - 1)) ? '0 : digit_idx + 1'b1;
        end
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    always_comb
    begin
        nibble           = disp_value[{digit_idx, 2'b00} +: 4];
        scan.abcdefgh    = hex_to_seg(nibble);
        scan.abcdefgh[0] = sign_point && (digit_idx == w_idx'(`W_DIGIT - 1));
        scan.digit       = board_pkg::digit_t'(1) << digit_idx;
    end

    // Thermometer bar from the shown magnitude
    always_comb
    begin
        for (int n = 0; n < `W_LED_BAR; n++)
            bar[n] = disp_mag >= (audio_pkg::magnitude_t'(1) << (bar_base + n));
    end

    a_digit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(scan.digit));

endmodule

`default_nettype wire

// File: src/seg_latch.sv
// Segment latch: turns the scanned digit bus into static active-low HEX digits and dp LEDs
`default_nettype none

`include "board_defs.svh"

module seg_latch
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire board_pkg::scan_s       scan,
    output board_pkg::hex_seg_t         hex0,
    output board_pkg::hex_seg_t         hex1,
    output board_pkg::hex_seg_t         hex2,
    output board_pkg::hex_seg_t         hex3,
    output board_pkg::hex_seg_t         hex4,
    output board_pkg::hex_seg_t         hex5,
    output board_pkg::digit_t           dp
);

    localparam int w_seg = $bits(board_pkg::seg_t);
    localparam int w_hex = $bits(board_pkg::hex_seg_t);

    board_pkg::seg_t        hgfedcba;
    board_pkg::hex_seg_t    hex_q [`W_DIGIT];

    // Bit reversal puts segment a at bit 0 and the point at the top
    always_comb
    begin
        for (int i = 0; i < w_seg; i++)
            hgfedcba[i] = scan.abcdefgh[w_seg - 1 - i];
    end

    // ---------------------------------------------------------------------------
    // Sticky digit registers

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int n = 0; n < `W_DIGIT; n++)
                hex_q[n] <= '1;     // Blank
            dp <= '0;
        end
        else
        begin
            for (int n = 0; n < `W_DIGIT; n++)
            begin
                if (scan.digit[n])
                begin
                    hex_q[n] <= ~hgfedcba[w_hex - 1:0];     // Pins are active low
                    dp[n]    <=  hgfedcba[w_hex];           // Point LEDs stay positive
                end
            end
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];
    assign hex4 = hex_q[4];
    assign hex5 = hex_q[5];

endmodule

`default_nettype wire

// File: verif/i2s_mic_model.sv
// INMP441 microphone model: shifts a 24-bit word out on sd in the left slot of each frame
`default_nettype none

module i2s_mic_model
(
    input  wire         sck,
    input  wire         ws,
    input  wire [23:0]  word,       // Word sent in the next left slot
    output logic        sd,
    output int          sent_cnt    // Words fully shifted out so far
);

    timeunit 1ns;
    timeprecision 100ps;

    logic        ws_prev     = 1'b0;
    logic        frame_start = 1'b0;
    logic        sd_q        = 1'b0;
    logic [23:0] shift_word  = '0;
    int          bit_idx     = -2;  // -2 idle, -1 last bit on the wire
    int          sent        = 0;

    assign sd       = sd_q;
    assign sent_cnt = sent;

    // ws seen low on the first rising sck after it fell
    always @(posedge sck)
    begin
        ws_prev     <= ws;
        frame_start <= ws_prev && !ws;
    end

    // Data changes on falling sck, MSB one period after ws falls
    always @(negedge sck)
    begin
        if (frame_start)
        begin
            shift_word <= word;
            sd_q       <= word[23];
            bit_idx    <= 22;
        end
        else if (bit_idx >= 0)
        begin
            sd_q    <= shift_word[bit_idx];
            bit_idx <= bit_idx - 1;
        end
        else if (bit_idx == -1)
        begin
            sd_q    <= 1'b0;        // LSB has been sampled by now
            bit_idx <= -2;
            sent    <= sent + 1;
        end
    end

endmodule

`default_nettype wire

// File: verif/mic_tests.txt
# sample mode clear expected_value bar sign_point
# sample and expected in hex, bar in binary with LEDR[3] first, mode 0 raw and 1 peak
123456 0 0 123456 0011 0
fedcba 0 0 fedcba 0000 1
07ffff 0 0 07ffff 0000 0
080000 0 0 080000 0001 0
0fffff 0 0 0fffff 0001 0
100000 0 0 100000 0011 0
1fffff 0 0 1fffff 0011 0
200000 0 0 200000 0111 0
3fffff 0 0 3fffff 0111 0
400000 0 0 400000 1111 0
f80000 0 0 f80000 0001 1
100000 1 1 100000 0011 0
e00000 1 0 200000 0111 0
1fffff 1 0 200000 0111 0
800000 1 0 7fffff 1111 0
050000 1 1 050000 0000 0
f80000 1 0 080000 0001 0
800000 0 0 800000 1111 1

// File: verif/tb_board_top.sv
// Testbench for the microphone level display that plays test words and checks HEX and LEDR
`default_nettype none

`include "board_defs.svh"

module tb_board_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int frame_cycles   = 128 * `I2S_SCK_DIV;    // 64 sck periods
    localparam int word_timeout   = 2 * frame_cycles;
    localparam int settle_timeout = 2 * frame_cycles;

    logic           clk;
    logic [3:0]     key;
    logic [9:0]     sw;
    wire  [9:0]     ledr;
    wire  [6:0]     hex0;
    wire  [6:0]     hex1;
    wire  [6:0]     hex2;
    wire  [6:0]     hex3;
    wire  [6:0]     hex4;
    wire  [6:0]     hex5;
    wire  [35:0]    gpio_0;
    logic [23:0]    mic_word;
    int             sent_cnt;
    int             value_errors;
    int             other_errors;
    int             step_line;

    always #2 clk = ~clk;   // 4 ns period

    board_top u_dut
    (
        .clk    (clk),
        .key    (key),
        .sw     (sw),
        .ledr   (ledr),
        .hex0   (hex0),
        .hex1   (hex1),
        .hex2   (hex2),
        .hex3   (hex3),
        .hex4   (hex4),
        .hex5   (hex5),
        .gpio_0 (gpio_0)
    );

    i2s_mic_model u_mic
    (
        .sck        (gpio_0[1]),
        .ws         (gpio_0[3]),
        .word       (mic_word),
        .sd         (gpio_0[0]),
        .sent_cnt   (sent_cnt)
    );

    // ------------------------------------------------------------------------
    // Expected patterns and output access

    // Active-low HEX pattern with segment a at bit 0
    function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
        logic [6:0] gfedcba;
        case (nibble)
            4'h0: gfedcba = 7'h3f;
            4'h1: gfedcba = 7'h06;
            4'h2: gfedcba = 7'h5b;
            4'h3: gfedcba = 7'h4f;
            4'h4: gfedcba = 7'h66;
            4'h5: gfedcba = 7'h6d;
            4'h6: gfedcba = 7'h7d;
            4'h7: gfedcba = 7'h07;
            4'h8: gfedcba = 7'h7f;
            4'h9: gfedcba = 7'h6f;
            4'ha: gfedcba = 7'h77;
            4'hb: gfedcba = 7'h7c;
            4'hc: gfedcba = 7'h39;
            4'hd: gfedcba = 7'h5e;
            4'he: gfedcba = 7'h79;
            default: gfedcba = 7'h71;
        endcase
        return ~gfedcba;
    endfunction

    function automatic logic [6:0] got_hex(input int n);
        case (n)
            0: return hex0;
            1: return hex1;
            2: return hex2;
            3: return hex3;
            4: return hex4;
            default: return hex5;
        endcase
    endfunction

    function automatic bit outputs_match(input logic [23:0] value, input logic [3:0] bar,
                                         input logic sign);
        bit ok;
        ok = (ledr[3:0] === bar) && (ledr[9] === sign) && (ledr[8:4] === '0);
        for (int n = 0; n < `W_DIGIT; n++)
        begin
            if (got_hex(n) !== seg_pattern(value[4 * n +: 4]))
                ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic report_value(input string name, input logic [23:0] expected,
                                input logic [23:0] got);
        $display("** Error at %0d ns: step line %0d, %s expected %0h, got %0h",
                 $time, step_line, name, expected, got);
        value_errors++;
    endtask

    // ------------------------------------------------------------------------
    // Stimulus and checks

    // Waits until the model has shifted out one more word
    task automatic wait_word();
        int start;
        int cycles;
        start  = sent_cnt;
        cycles = 0;
        while (sent_cnt == start && cycles < word_timeout)
        begin
            @(negedge clk);
            cycles++;
        end
        if (sent_cnt == start)
        begin
            $display("Timeout at %0d ns: no I2S word finished for line %0d", $time, step_line);
            other_errors++;
        end
    endtask

    task automatic pulse_clear();
        @(posedge clk);
        key[0] <= 1'b0;     // Key 0 pressed
        repeat (3) @(posedge clk);
        key[0] <= 1'b1;
    endtask

    task automatic wait_settle(input logic [23:0] value, input logic [3:0] bar,
                               input logic sign);
        int cycles;
        cycles = 0;
        while (!outputs_match(value, bar, sign) && cycles < settle_timeout)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!outputs_match(value, bar, sign))
        begin
            $display("Timeout at %0d ns: display did not settle for line %0d", $time, step_line);
            other_errors++;
        end
    endtask

    task automatic check_outputs(input logic [23:0] value, input logic [3:0] bar,
                                 input logic sign);
        logic [6:0] exp_seg;
        for (int n = 0; n < `W_DIGIT; n++)
        begin
            exp_seg = seg_pattern(value[4 * n +: 4]);
            if (got_hex(n) !== exp_seg)
                report_value($sformatf("hex%0d", n), 24'(exp_seg), 24'(got_hex(n)));
        end
        if (ledr[3:0] !== bar)
            report_value("ledr[3:0]", 24'(bar), 24'(ledr[3:0]));
        if (ledr[9] !== sign)
            report_value("ledr[9]", 24'(sign), 24'(ledr[9]));
        if (ledr[8:4] !== '0)
            report_value("ledr[8:4]", 24'h0, 24'(ledr[8:4]));

        // Microphone power and channel select pins
        if (gpio_0[2] !== 1'b1)
            report_value("gpio_0[2]", 24'h1, 24'(gpio_0[2]));
        if (gpio_0[4] !== 1'b0)
            report_value("gpio_0[4]", 24'h0, 24'(gpio_0[4]));
        if (gpio_0[5] !== 1'b0)
            report_value("gpio_0[5]", 24'h0, 24'(gpio_0[5]));
    endtask

    // Blank display while reset is held
    task automatic check_blank();
        for (int n = 0; n < `W_DIGIT; n++)
        begin
            if (got_hex(n) !== 7'h7f)
                report_value($sformatf("hex%0d", n), 24'h7f, 24'(got_hex(n)));
        end
        if (ledr !== '0)
            report_value("ledr", 24'h0, 24'(ledr));
    endtask

    // ------------------------------------------------------------------------
    // Main sequence

    initial
    begin
        int          fd;
        int          fields;
        int          line_no;
        int          steps;
        int          mode_in;
        int          clear_in;
        int          sign_in;
        string       line;
        logic [23:0] smp;
        logic [23:0] exp_val;
        logic [3:0]  exp_bar;

        clk          = 1'b0;
        key          = 4'hf;
        sw           = 10'h200;     // Reset on switch 9
        mic_word     = '0;
        value_errors = 0;
        other_errors = 0;
        step_line    = 0;
        line_no      = 0;
        steps        = 0;

        repeat (9) @(posedge clk);
        @(negedge clk);
        check_blank();
        @(posedge clk);
        sw[9] <= 1'b0;

        fd = $fopen("verif/mic_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open verif/mic_tests.txt");
            other_errors++;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                line_no++;
                if (line.len() < 2 || line[0] == "#")
                    continue;
                fields = $sscanf(line, "%h %d %d %h %b %d",
                                 smp, mode_in, clear_in, exp_val, exp_bar, sign_in);
                if (fields != 6)
                begin
                    $display("Line %0d of the test file is malformed", line_no);
                    other_errors++;
                    continue;
                end
                step_line = line_no;

                @(posedge clk);
                mic_word <= smp;
                sw[0]    <= mode_in[0];
                wait_word();            // May still carry the previous word
                if (clear_in != 0)
                    pulse_clear();
                wait_word();
                wait_settle(exp_val, exp_bar, sign_in[0]);
                check_outputs(exp_val, exp_bar, sign_in[0]);
                steps++;
            end
            $fclose(fd);
        end

        if (steps == 0)
        begin
            $display("No test steps were run");
            other_errors++;
        end

        $display("Steps: %0d, value errors: %0d, other errors: %0d",
                 steps, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
